// ==== list.f ====
verilog/rv_nibble_pkg.sv
verilog/instr_decoder.sv
verilog/nibble_alu.sv
verilog/reg_file.sv
verilog/apb_mem_port.sv
verilog/control_fsm.sv
verilog/nibble_core.sv
sim/apb_mem_model.sv
sim/tb_nibble_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the nibble core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_nibble_core -o tb_nibble_core
./obj_dir/tb_nibble_core | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    exit 1
fi
exit 0

// ==== sim/tb_nibble_core.sv ====
`timescale 1ns/10ps

module tb_nibble_core import rv_nibble_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    apb_req_s    apb_out;
    apb_rsp_s    apb_in;
    logic        halted;
    logic [31:0] row_instr [$];   // tested word
    logic [31:0] row_x5 [$];      // expected x5
    logic        row_taken [$];   // marker skipped
    string       row_name [$];
    int          n_rows = 0;
    int          passed = 0;
    int          failed = 0;

    nibble_core #(.START_ADDR(32'h100)) i_nibble_core (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable),
        .apb_out(apb_out), .apb_in(apb_in), .halted(halted)
    );

    apb_mem_model i_apb_mem_model (
        .clk(clk), .psel(psel), .penable(penable), .req(apb_out), .rsp(apb_in),
        .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // RV32I encodings
    function automatic logic [31:0] rtype(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] itype(int opc, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] stype(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};  // sw
    endfunction

    function automatic logic [31:0] btype(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] utype(int opc, int rd, int imm);
        return {imm[19:0], rd[4:0], opc[6:0]};  // imm is the upper 20 bits
    endfunction

    function automatic logic [31:0] jtype(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic add_row(input logic [31:0] instr, input logic [31:0] x5,
                           input logic taken, input string name);
        row_instr.push_back(instr);
        row_x5.push_back(x5);
        row_taken.push_back(taken);
        row_name.push_back(name);
    endtask

    task automatic build_table();
        add_row(itype('h13, 0, 5, 7, -5), 32'h00000025, 0, "addi");
        add_row(rtype(0, 0, 5, 6, 7), 32'hcafebae8, 0, "add");
        add_row(rtype('h20, 0, 5, 8, 7), 32'hffffffec, 0, "sub");
        add_row(rtype(0, 7, 5, 6, 5), 32'hcaacbaae, 0, "and");
        add_row(rtype(0, 6, 5, 6, 5), 32'hdeffbeff, 0, "or");
        add_row(rtype(0, 4, 5, 6, 5), 32'h14530451, 0, "xor");
        add_row(rtype(0, 1, 5, 6, 9), 32'h2bfaeaf8, 0, "sll 2");
        add_row(rtype(0, 1, 5, 6, 0), 32'hcafebabe, 0, "sll 0");
        add_row(rtype(0, 5, 5, 6, 9), 32'h32bfaeaf, 0, "srl 2");
        add_row(rtype(0, 5, 5, 6, 0), 32'hcafebabe, 0, "srl 0");
        add_row(rtype('h20, 5, 5, 6, 9), 32'hf2bfaeaf, 0, "sra 2");  // negative source
        add_row(rtype('h20, 5, 5, 6, 0), 32'hcafebabe, 0, "sra 0");
        add_row(itype('h13, 1, 5, 6, 2), 32'h2bfaeaf8, 0, "slli 2");
        add_row(itype('h13, 1, 5, 6, 0), 32'hcafebabe, 0, "slli 0");
        add_row(itype('h13, 5, 5, 6, 2), 32'h32bfaeaf, 0, "srli 2");
        add_row(itype('h13, 5, 5, 6, 0), 32'hcafebabe, 0, "srli 0");
        add_row(itype('h13, 5, 5, 5, 'h402), 32'hf7ab6fbb, 0, "srai 2");
        add_row(itype('h13, 5, 5, 5, 'h400), 32'hdeadbeef, 0, "srai 0");
        add_row(utype('h37, 5, 'h12345), 32'h12345000, 0, "lui");
        add_row(utype('h17, 5, 'h12345), 32'h12345138, 0, "auipc");    // pc 0x138
        add_row(jtype(5, 8), 32'h0000013c, 1, "jal");
        add_row(itype('h67, 0, 5, 3, 'h40), 32'h0000013c, 1, "jalr");   // to 0x140
        add_row(btype(0, 7, 7, 8), 32'hdeadbeef, 1, "beq taken");
        add_row(btype(0, 7, 8, 8), 32'hdeadbeef, 0, "beq not");
        add_row(btype(1, 7, 8, 8), 32'hdeadbeef, 1, "bne taken");
        add_row(btype(1, 7, 7, 8), 32'hdeadbeef, 0, "bne not");
        add_row(btype(4, 6, 7, 8), 32'hdeadbeef, 1, "blt taken");
        add_row(btype(4, 7, 6, 8), 32'hdeadbeef, 0, "blt not");
        add_row(btype(5, 7, 6, 8), 32'hdeadbeef, 1, "bge taken");
        add_row(btype(5, 7, 7, 8), 32'hdeadbeef, 1, "bge equal");
        add_row(btype(5, 6, 7, 8), 32'hdeadbeef, 0, "bge not");
        add_row(btype(6, 7, 6, 8), 32'hdeadbeef, 1, "bltu taken");
        add_row(btype(6, 6, 7, 8), 32'hdeadbeef, 0, "bltu not");
        add_row(btype(7, 6, 7, 8), 32'hdeadbeef, 1, "bgeu taken");
        add_row(btype(7, 8, 7, 8), 32'hdeadbeef, 0, "bgeu not");
        add_row(itype('h03, 2, 5, 3, 8), 32'hfeff1111, 0, "lw");
        add_row(stype(6, 4, -8), 32'hdeadbeef, 0, "sw");
    endtask

    task automatic load_program(input logic [31:0] tested);
        i_apb_mem_model.clear();
        i_apb_mem_model.load_word(32'h100, jtype(0, 16));          // hop over data words
        i_apb_mem_model.load_word(32'h108, 32'hfeff1111);
        i_apb_mem_model.load_word(32'h110, itype('h13, 0, 3, 0, 'h100));
        i_apb_mem_model.load_word(32'h114, itype('h13, 0, 4, 0, 'h110));
        i_apb_mem_model.load_word(32'h118, utype('h37, 5, 'hdeadc));
        i_apb_mem_model.load_word(32'h11c, itype('h13, 0, 5, 5, -'h111));
        i_apb_mem_model.load_word(32'h120, utype('h37, 6, 'hcafec));
        i_apb_mem_model.load_word(32'h124, itype('h13, 0, 6, 6, -'h542));
        i_apb_mem_model.load_word(32'h128, itype('h13, 0, 7, 0, 'h2a));
        i_apb_mem_model.load_word(32'h12c, itype('h13, 0, 8, 0, 'h16));
        i_apb_mem_model.load_word(32'h130, itype('h13, 0, 9, 0, 2));
        i_apb_mem_model.load_word(32'h134, itype('h13, 0, 11, 0, 0));
        i_apb_mem_model.load_word(32'h138, tested);
        i_apb_mem_model.load_word(32'h13c, itype('h13, 0, 12, 0, 1));  // skip marker
        i_apb_mem_model.load_word(32'h140, stype(5, 3, 'h100));       // x5 to 0x200
        i_apb_mem_model.load_word(32'h144, stype(12, 3, 'h104));      // x12 to 0x204
        i_apb_mem_model.load_word(32'h148, 32'h0);                    // illegal, halts
    endtask

    task automatic run_row(input int r);
        logic [31:0] got_x5;
        logic [31:0] got_x12;
        logic [31:0] got_word;
        logic [31:0] exp_x12;
        logic [31:0] exp_word;
        logic [31:0] addr_x5;
        logic [31:0] addr_x12;
        int          n;
        int          errs;
        int          bus_errs;            // model errors before this row
        errs = 0;
        bus_errs = i_apb_mem_model.err_count;
        @(posedge clk);
        #1 rst_n = 1'b0;
        load_program(row_instr[r]);
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        while (halted !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        n = i_apb_mem_model.wr_data.size();
        assert (n >= 2) else begin
            $display("t=%0t %s: the two result stores never reached the bus", $time,
                     row_name[r]);
            errs++;
        end
        if (n >= 2) begin
            got_x5   = i_apb_mem_model.wr_data[n-2];
            got_x12  = i_apb_mem_model.wr_data[n-1];
            addr_x5  = i_apb_mem_model.wr_addr[n-2];
            addr_x12 = i_apb_mem_model.wr_addr[n-1];
            exp_x12  = row_taken[r] ? 32'd0 : 32'd1;  // marker ran unless skipped
            assert (addr_x5 == 32'h200) else begin
                $display("MISMATCH t=%0t x5 store paddr got %h expected %h (%s)", $time,
                         addr_x5, 32'h200, row_name[r]);
                errs++;
            end
            assert (addr_x12 == 32'h204) else begin
                $display("MISMATCH t=%0t x12 store paddr got %h expected %h (%s)", $time,
                         addr_x12, 32'h204, row_name[r]);
                errs++;
            end
            assert (got_x5 == row_x5[r]) else begin
                $display("MISMATCH t=%0t x5 got %h expected %h (%s)", $time, got_x5,
                         row_x5[r], row_name[r]);
                errs++;
            end
            assert (got_x12 == exp_x12) else begin
                $display("MISMATCH t=%0t x12 got %h expected %h (%s)", $time, got_x12,
                         exp_x12, row_name[r]);
                errs++;
            end
        end
        got_word = i_apb_mem_model.mem[8'h42];                        // word 0x108
        exp_word = (row_instr[r][6:0] == 7'h23) ? 32'hcafebabe : 32'hfeff1111;
        assert (got_word == exp_word) else begin
            $display("MISMATCH t=%0t mem[0x108] got %h expected %h (%s)", $time, got_word,
                     exp_word, row_name[r]);
            errs++;
        end
        assert (i_apb_mem_model.err_count == bus_errs) else begin
            $display("t=%0t %s: the bus broke protocol during this row", $time,
                     row_name[r]);
            errs++;
        end
        if (errs == 0) begin
            passed++;
            $display("t=%0t pass %s", $time, row_name[r]);
        end else begin
            failed++;
        end
    endtask

    initial begin
        wait (n_rows > 0);
        repeat (n_rows * 400) @(posedge clk);
        $display("timeout: the core never halted within %0d cycles", n_rows * 400);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        build_table();
        n_rows = row_instr.size();
        for (int r = 0; r < n_rows; r++)
            run_row(r);
        $display("%0d rows, %0d passed, %0d failed, %0d bus check errors", n_rows, passed,
                 failed, i_apb_mem_model.err_count);
        if (failed == 0 && i_apb_mem_model.err_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== sim/apb_mem_model.sv ====
`timescale 1ns/10ps

module apb_mem_model import rv_nibble_pkg::*; (
    input  logic     clk,
    input  logic     psel,
    input  logic     penable,
    input  apb_req_s req,
    output apb_rsp_s rsp,
    input  logic     halted
);

    logic [XLEN-1:0] mem [0:255];        // 1 KiB, word index paddr[9:2]
    logic [XLEN-1:0] wr_addr [$];        // write log in bus order
    logic [XLEN-1:0] wr_data [$];
    int              seed = 32'h2541e5ba;
    int              wait_left;          // wait states still owed
    int              err_count = 0;
    logic            prev_psel = 1'b0;   // bus as seen in the cycle before
    logic            prev_penable = 1'b0;
    logic            prev_ready = 1'b0;
    logic            prev_halted = 1'b0;
    apb_req_s        prev_req;

    initial rsp = '0;

    task automatic clear();
        for (int i = 0; i < 256; i++)
            mem[i] = 32'h5a5a_0000 ^ (i << 2);  // pattern from the byte address
        wr_addr.delete();
        wr_data.delete();
    endtask

    task automatic load_word(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        mem[addr[9:2]] = data;
    endtask

    always @(posedge clk) begin
        if (penable)
            assert (psel && prev_psel) else begin
                $display("t=%0t bus error: access cycle without a setup cycle", $time);
                err_count++;
            end
        if (prev_psel && !(prev_penable && prev_ready))
            assert (psel && penable && req == prev_req) else begin
                $display("t=%0t bus error: transfer changed or dropped before pready", $time);
                err_count++;
            end
        if (psel && penable && rsp.pready) begin   // completing edge
            assert (req.paddr < 32'h400 && req.paddr[1:0] == 2'b00) else begin
                $display("t=%0t bus error: address %h outside the memory", $time, req.paddr);
                err_count++;
            end
            if (req.pwrite) begin
                mem[req.paddr[9:2]] = req.pwdata;
                wr_addr.push_back(req.paddr);
                wr_data.push_back(req.pwdata);
            end
        end
        if (halted)
            assert (!psel) else begin
                $display("t=%0t bus error: transfer started while halted", $time);
                err_count++;
            end
        if (halted && !prev_halted)
            assert (wr_addr.size() >= 2 && wr_addr[wr_addr.size()-1] == 32'h204) else begin
                $display("t=%0t core halted before its final stores", $time);
                err_count++;
            end
        prev_psel    = psel;
        prev_penable = penable;
        prev_ready   = rsp.pready;
        prev_halted  = halted;
        prev_req     = req;
        #1;                                       // response driven after the edge
        if (psel && !penable)
            wait_left = $random(seed) & 3;        // 0 to 3 wait states
        rsp.pready = psel && penable && (wait_left == 0);
        if (psel && penable && wait_left > 0)
            wait_left = wait_left - 1;
        rsp.prdata = mem[req.paddr[9:2]];
    end

endmodule

// ==== verilog/nibble_core.sv ====
`timescale 1ns/10ps

module nibble_core import rv_nibble_pkg::*; #(
    parameter logic [XLEN-1:0] START_ADDR = 32'h0
) (
    input  logic     clk,
    input  logic     rst_n,
    output logic     psel,
    output logic     penable,
    output apb_req_s apb_out,
    input  apb_rsp_s apb_in,
    output logic     halted
);

    rv_instr_u       instr;
    ctrl_s           ctrl;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic            alu_start;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    alu_op_e         alu_op;
    logic [XLEN-1:0] alu_result;
    logic            alu_flag;
    logic            alu_done;
    logic            mem_req;
    apb_req_s        mem_cmd;
    logic [XLEN-1:0] mem_rdata;
    logic            mem_done;
    logic            rd_we;
    logic [XLEN-1:0] rd_wdata;

    control_fsm #(.START_ADDR(START_ADDR)) i_control_fsm (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .imm(imm),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .instr(instr),
        .alu_start(alu_start), .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op),
        .alu_result(alu_result), .alu_flag(alu_flag), .alu_done(alu_done),
        .mem_req(mem_req), .mem_cmd(mem_cmd), .mem_rdata(mem_rdata), .mem_done(mem_done),
        .rd_we(rd_we), .rd_wdata(rd_wdata), .halted(halted)
    );

    instr_decoder i_instr_decoder (.instr(instr), .ctrl(ctrl), .imm(imm));

    nibble_alu i_nibble_alu (
        .clk(clk), .rst_n(rst_n), .start(alu_start), .op(alu_op), .a(alu_a), .b(alu_b),
        .result(alu_result), .flag(alu_flag), .done(alu_done)
    );

    reg_file i_reg_file (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(instr.r.rs1), .rs2_addr(instr.r.rs2), .rd_addr(instr.r.rd),  // fixed spots
        .rd_we(rd_we), .rd_wdata(rd_wdata), .rs1_val(rs1_val), .rs2_val(rs2_val)
    );

    apb_mem_port i_apb_mem_port (
        .clk(clk), .rst_n(rst_n), .req(mem_req), .cmd(mem_cmd),
        .rdata(mem_rdata), .done(mem_done), .psel(psel), .penable(penable),
        .apb_out(apb_out), .apb_in(apb_in)
    );

endmodule

// ==== verilog/control_fsm.sv ====
`timescale 1ns/10ps

module control_fsm import rv_nibble_pkg::*; #(
    parameter logic [XLEN-1:0] START_ADDR = 32'h0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  ctrl_s           ctrl,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] rs1_val,
    input  logic [XLEN-1:0] rs2_val,
    output rv_instr_u       instr,
    output logic            alu_start,
    output logic [XLEN-1:0] alu_a,
    output logic [XLEN-1:0] alu_b,
    output alu_op_e         alu_op,
    input  logic [XLEN-1:0] alu_result,
    input  logic            alu_flag,
    input  logic            alu_done,
    output logic            mem_req,
    output apb_req_s        mem_cmd,
    input  logic [XLEN-1:0] mem_rdata,
    input  logic            mem_done,
    output logic            rd_we,
    output logic [XLEN-1:0] rd_wdata,
    output logic            halted
);

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_error
    } state_e;

    state_e          state;
    logic [XLEN-1:0] pc;
    rv_instr_u       ir;
    logic [XLEN-1:0] res;        // alu result, address or jump target
    logic            taken;      // compare after invert
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_branch;  // own target adder

    assign instr     = ir;
    assign pc_plus4  = pc + 32'd4;
    assign pc_branch = pc + imm;
    assign alu_op    = ctrl.alu_op;
    assign alu_a     = ctrl.src_a_pc ? pc : rs1_val;
    assign alu_b     = ctrl.src_b_imm ? imm : rs2_val;
    assign alu_start = (state == st_decode) && !ctrl.illegal;  // one pulse per instr
    assign halted    = (state == st_error);
    assign mem_req   = (state == st_fetch) || (state == st_memory);
    assign rd_we     = (state == st_writeback) && ctrl.reg_write;

    always_comb begin
        mem_cmd       = '0;
        mem_cmd.paddr = pc;                            // fetch read
        if (state == st_memory) begin
            mem_cmd.paddr  = res;                      // lw/sw address from alu
            mem_cmd.pwrite = ctrl.is_store;
            mem_cmd.pwdata = rs2_val;
        end
    end

    always_comb begin
        case (ctrl.wb_sel)
            wb_load: rd_wdata = load_data;
            wb_pc4:  rd_wdata = pc_plus4;              // jal, jalr link
            default: rd_wdata = res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_fetch;
            pc    <= START_ADDR;
        end else begin
            case (state)
                st_fetch: begin
                    if (mem_done)
                        state <= st_decode;
                end
                st_decode: state <= ctrl.illegal ? st_error : st_execute;
                st_execute: begin
                    if (alu_done)
                        state <= (ctrl.is_load || ctrl.is_store) ? st_memory : st_writeback;
                end
                st_memory: begin
                    if (mem_done)
                        state <= st_writeback;
                end
                st_writeback: begin
                    state <= st_fetch;
                    if (ctrl.is_jump)
                        pc <= {res[XLEN-1:1], 1'b0};   // jalr clears bit 0
                    else if (ctrl.is_branch && taken)
                        pc <= pc_branch;
                    else
                        pc <= pc_plus4;
                end
                default: state <= st_error;            // stuck until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch && mem_done)
            ir <= mem_rdata;
        if (state == st_execute && alu_done) begin
            res   <= alu_result;
            taken <= alu_flag ^ ctrl.branch_invert;
        end
        if (state == st_memory && mem_done)
            load_data <= mem_rdata;
    end

endmodule

// ==== verilog/apb_mem_port.sv ====
`timescale 1ns/10ps

module apb_mem_port import rv_nibble_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req,      // held until done
    input  apb_req_s        cmd,
    output logic [XLEN-1:0] rdata,
    output logic            done,
    output logic            psel,
    output logic            penable,
    output apb_req_s        apb_out,
    input  apb_rsp_s        apb_in
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } state_e;

    state_e   state;
    apb_req_s cmd_q;  // bus copy, steady through wait states

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            cmd_q <= '0;                               // pwrite low out of reset
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        state <= st_setup;
                        cmd_q <= cmd;
                    end
                end
                st_setup: state <= st_access;
                st_access: begin
                    if (apb_in.pready)
                        state <= st_idle;              // sequencer drops req after done
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign psel    = (state != st_idle);
    assign penable = (state == st_access);
    assign apb_out = cmd_q;
    assign done    = penable && apb_in.pready;     // completing edge
    assign rdata   = apb_in.prdata;

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/10ps

module reg_file import rv_nibble_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    input  logic [4:0]      rd_addr,
    input  logic            rd_we,
    input  logic [XLEN-1:0] rd_wdata,
    output logic [XLEN-1:0] rs1_val,
    output logic [XLEN-1:0] rs2_val
);

    logic [XLEN-1:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (rd_we && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_wdata;                 // writes to x0 dropped
        end
    end

    assign rs1_val = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_val = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== verilog/nibble_alu.sv ====
`timescale 1ns/10ps

module nibble_alu import rv_nibble_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  alu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result,
    output logic            flag,
    output logic            done
);

    logic            busy;    // op in progress
    logic            serial;  // nibble walk, else shift or pass
    logic [2:0]      idx;     // nibble being worked
    logic [4:0]      shamt;   // bits still to shift
    logic            carry;   // carry into this nibble
    logic            zero;    // lower nibbles all zero so far
    logic [XLEN-1:0] acc;     // finished nibbles or shift value
    logic            inv_b;   // subtract form
    logic [3:0]      a_nib;
    logic [3:0]      b_nib;
    logic [3:0]      nib;     // this nibble's result
    logic [4:0]      sum;

    assign inv_b = (op == alu_sub) || (op == alu_eq) || (op == alu_lt) || (op == alu_ltu);
    assign a_nib = a[idx*4 +: 4];                  // operands held stable by caller
    assign b_nib = b[idx*4 +: 4] ^ {4{inv_b}};
    assign sum   = a_nib + b_nib + carry;          // the 4-bit slice

    always_comb begin
        case (op)
            alu_and: nib = a_nib & b_nib;
            alu_or:  nib = a_nib | b_nib;
            alu_xor: nib = a_nib ^ b_nib;
            default: nib = sum[3:0];
        endcase
    end

    // last nibble joins the result in the done cycle
    assign done   = busy && (serial ? (idx == 3'd7) : (shamt == 5'd0));
    assign result = serial ? {nib, acc[27:0]} : acc;

    always_comb begin
        case (op)
            alu_eq:  flag = zero && (sum[3:0] == 4'd0);
            alu_lt:  flag = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : !sum[4];  // signs decide
            alu_ltu: flag = !sum[4];                                           // borrow out
            default: flag = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            serial <= 1'b0;
            idx    <= '0;
            shamt  <= '0;
            carry  <= 1'b0;
            zero   <= 1'b1;
        end else if (start) begin
            busy   <= 1'b1;
            serial <= !(op inside {alu_sll, alu_srl, alu_sra, alu_pass_b});
            idx    <= '0;
            shamt  <= (op == alu_pass_b) ? 5'd0 : b[4:0];  // pass done next cycle
            carry  <= inv_b;                               // +1 for two's complement
            zero   <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (serial) begin
                idx   <= idx + 3'd1;
                carry <= sum[4];
                zero  <= zero && (sum[3:0] == 4'd0);
            end else begin
                shamt <= shamt - 5'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc <= (op == alu_pass_b) ? b : a;
        end else if (busy && serial) begin
            acc[idx*4 +: 4] <= nib;                        // store finished nibble
        end else if (busy && !done) begin
            case (op)                                      // one bit per cycle
                alu_sll: acc <= {acc[XLEN-2:0], 1'b0};
                alu_srl: acc <= {1'b0, acc[XLEN-1:1]};
                alu_sra: acc <= {acc[XLEN-1], acc[XLEN-1:1]};
                default: acc <= acc;
            endcase
        end
    end

endmodule

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder import rv_nibble_pkg::*; (
    input  rv_instr_u       instr,
    output ctrl_s           ctrl,
    output logic [XLEN-1:0] imm
);

    logic [2:0] f3;
    logic       f7_zero;
    logic       f7_alt;   // sub / sra marker
    alu_op_e    rr_op;    // op from funct3, reg and shift-imm forms
    logic       rr_bad;

    assign f3      = instr.r.funct3;
    assign f7_zero = (instr.r.funct7 == 7'b0000000);
    assign f7_alt  = (instr.r.funct7 == 7'b0100000);

    always_comb begin
        rr_op  = alu_add;
        rr_bad = 1'b0;
        case (f3)
            3'b000:  rr_op = f7_alt ? alu_sub : alu_add;
            3'b001:  rr_op = alu_sll;
            3'b100:  rr_op = alu_xor;
            3'b101:  rr_op = f7_alt ? alu_sra : alu_srl;
            3'b110:  rr_op = alu_or;
            3'b111:  rr_op = alu_and;
            default: rr_bad = 1'b1;  // slt, sltu left out
        endcase
        if (!f7_zero && !(f7_alt && (f3 == 3'b000 || f3 == 3'b101)))
            rr_bad = 1'b1;  // bad funct7
    end

    always_comb begin
        ctrl = '0;                                     // add, wb alu, nothing set
        imm  = {{20{instr.i.imm[11]}}, instr.i.imm};  // i-type unless overridden
        case (instr.r.opcode)
            op_lui: begin
                imm            = {instr.u.imm, 12'b0};
                ctrl.alu_op    = alu_pass_b;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_auipc: begin
                imm            = {instr.u.imm, 12'b0};
                ctrl.src_a_pc  = 1'b1;                 // pc + imm
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_jal: begin
                imm            = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                                  instr.j.imm_11, instr.j.imm_10_1, 1'b0};
                ctrl.src_a_pc  = 1'b1;                 // target on the alu
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_pc4;
                ctrl.is_jump   = 1'b1;
            end
            op_jalr: begin
                ctrl.src_b_imm = 1'b1;                 // rs1 + imm
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_pc4;
                ctrl.is_jump   = 1'b1;
                ctrl.illegal   = (f3 != 3'b000);
            end
            op_branch: begin
                imm                = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                                      instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
                ctrl.is_branch     = 1'b1;
                ctrl.branch_invert = f3[0];            // bne, bge, bgeu
                case (f3[2:1])
                    2'b00:   ctrl.alu_op = alu_eq;
                    2'b10:   ctrl.alu_op = alu_lt;
                    2'b11:   ctrl.alu_op = alu_ltu;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            op_load: begin
                ctrl.src_b_imm = 1'b1;                 // address rs1 + imm
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_load;
                ctrl.is_load   = 1'b1;
                ctrl.illegal   = (f3 != 3'b010);       // lw only
            end
            op_store: begin
                imm            = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
                ctrl.src_b_imm = 1'b1;
                ctrl.is_store  = 1'b1;
                ctrl.illegal   = (f3 != 3'b010);       // sw only
            end
            op_imm: begin
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                if (f3 == 3'b000) begin
                    ctrl.alu_op = alu_add;             // addi
                end else if (f3[1:0] == 2'b01) begin
                    ctrl.alu_op  = rr_op;              // slli, srli, srai
                    ctrl.illegal = rr_bad;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            op_reg: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = rr_op;
                ctrl.illegal   = rr_bad;
            end
            default: ctrl.illegal = 1'b1;              // unknown opcode
        endcase
    end

endmodule

// ==== verilog/rv_nibble_pkg.sv ====
package rv_nibble_pkg;

    localparam int XLEN = 32;  // word width

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_s;

    typedef struct packed {
        logic [6:0] imm_hi;  // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;  // imm[4:0]
        opcode_e    opcode;
    } s_fmt_s;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_s;

    typedef struct packed {
        logic [19:0] imm;  // imm[31:12]
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_s;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_s;

    typedef union packed {
        r_fmt_s r;
        i_fmt_s i;
        s_fmt_s s;
        b_fmt_s b;
        u_fmt_s u;
        j_fmt_s j;
    } rv_instr_u;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_eq,
        alu_lt,
        alu_ltu,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc4
    } wb_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    src_a_pc;       // pc as operand a
        logic    src_b_imm;      // immediate as operand b
        logic    reg_write;
        wb_sel_e wb_sel;
        logic    is_load;
        logic    is_store;
        logic    is_branch;
        logic    is_jump;
        logic    branch_invert;  // taken on false compare
        logic    illegal;
    } ctrl_s;

    typedef struct packed {
        logic [XLEN-1:0] paddr;
        logic            pwrite;
        logic [XLEN-1:0] pwdata;
    } apb_req_s;

    typedef struct packed {
        logic [XLEN-1:0] prdata;
        logic            pready;
    } apb_rsp_s;

endpackage
